// File: isa_pkg.sv
//--------------------------------------------------------------------------
// Architectural types of the RV32 frontend
// Data word, register index, opcode and the decoded instruction
//--------------------------------------------------------------------------
`default_nettype none

package isa_pkg;

    // Data width and register file size
    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;

    typedef logic [XLEN-1:0]              xlen_t;
    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [6:0]                   opcode_t;

    // One instruction as it leaves decode
    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        opcode_t   opcode;
        arch_reg_t rd;
        logic      has_rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        // Operand b comes from imm instead of rs2
        logic      use_imm;
        xlen_t     imm;
    } decoded_inst_t;

endpackage

`default_nettype wire

// File: uarch_pkg.sv
//--------------------------------------------------------------------------
// Microarchitecture types of the rename stage
// ROB tags, source operands, renamed instructions, RAT and commit ports
// Slot 0 of every group is the older instruction
//--------------------------------------------------------------------------
`default_nettype none

package uarch_pkg;

    import isa_pkg::*;

    // Two instructions per cycle, 16 ROB entries
    localparam int PIPE_WIDTH = 2;
    localparam int TAG_WIDTH  = 4;
    localparam int ROB_DEPTH  = 1 << TAG_WIDTH;

    typedef logic [TAG_WIDTH-1:0] rob_tag_t;

    // Either a pending producer tag or a ready value
    typedef struct packed {
        logic     is_renamed;
        rob_tag_t tag;
        xlen_t    data;
    } source_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        opcode_t   opcode;
        arch_reg_t rd;
        logic      has_rd;
        rob_tag_t  dest_tag;
        source_t   src_a;
        source_t   src_b;
    } renamed_inst_t;

    typedef struct packed {
        logic      we;
        arch_reg_t addr;
        rob_tag_t  tag;
    } rat_write_t;

    // Retire port of the ROB
    typedef struct packed {
        logic      we;
        rob_tag_t  tag;
        arch_reg_t rd;
        logic      has_rd;
        xlen_t     data;
    } commit_port_t;

    typedef decoded_inst_t [PIPE_WIDTH-1:0] decoded_group_t;
    typedef renamed_inst_t [PIPE_WIDTH-1:0] renamed_group_t;
    typedef rat_write_t    [PIPE_WIDTH-1:0] rat_write_group_t;
    typedef commit_port_t  [PIPE_WIDTH-1:0] commit_group_t;
    typedef rob_tag_t      [PIPE_WIDTH-1:0] tag_group_t;

endpackage

`default_nettype wire

// File: reg_status_file.sv
//--------------------------------------------------------------------------
// Register status file
// Rename table (valid bit and ROB tag per register) merged with the
// architectural values, async source reads, rename and commit writes
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module reg_status_file (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           flush,
    input  isa_pkg::arch_reg_t [uarch_pkg::PIPE_WIDTH-1:0] rs1,
    input  isa_pkg::arch_reg_t [uarch_pkg::PIPE_WIDTH-1:0] rs2,
    output uarch_pkg::source_t [uarch_pkg::PIPE_WIDTH-1:0] rs1_read,
    output uarch_pkg::source_t [uarch_pkg::PIPE_WIDTH-1:0] rs2_read,
    input  uarch_pkg::rat_write_group_t                    rat_writes,
    input  uarch_pkg::commit_group_t                       commit_ports
);
    import isa_pkg::*;
    import uarch_pkg::*;

    logic     map_valid [ARCH_REGS];
    rob_tag_t map_tag   [ARCH_REGS];
    xlen_t    arch_val  [ARCH_REGS];

    //--------------------------------------------------------------------------
    // Source reads
    //--------------------------------------------------------------------------
    function automatic source_t read_src(input arch_reg_t r);
        source_t s;
        s = '0;
        // x0 is hardwired to zero and never renamed
        if (r != '0) begin
            if (map_valid[r]) begin
                s.is_renamed = 1'b1;
                s.tag        = map_tag[r];
            end else begin
                s.data = arch_val[r];
            end
        end
        return s;
    endfunction

    always_comb begin
        for (int i = 0; i < PIPE_WIDTH; i++) begin
            rs1_read[i] = read_src(rs1[i]);
            rs2_read[i] = read_src(rs2[i]);
        end
    end

    //--------------------------------------------------------------------------
    // Table updates
    //--------------------------------------------------------------------------
    // Mapping valid bits: commit clear first, rename set overrides it
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                map_valid[r] <= 1'b0;
            end
        end else begin
            for (int c = 0; c < PIPE_WIDTH; c++) begin
                // Only drop the mapping if no younger producer took rd
                if (commit_ports[c].we && commit_ports[c].has_rd &&
                    map_valid[commit_ports[c].rd] &&
                    map_tag[commit_ports[c].rd] == commit_ports[c].tag) begin
                    map_valid[commit_ports[c].rd] <= 1'b0;
                end
            end
            for (int w = 0; w < PIPE_WIDTH; w++) begin
                if (rat_writes[w].we && rat_writes[w].addr != '0) begin
                    map_valid[rat_writes[w].addr] <= 1'b1;
                end
            end
        end
    end

    // Producer tags, slot 1 written last so it wins on equal rd
    always_ff @(posedge clk) begin
        for (int w = 0; w < PIPE_WIDTH; w++) begin
            if (rat_writes[w].we && rat_writes[w].addr != '0) begin
                map_tag[rat_writes[w].addr] <= rat_writes[w].tag;
            end
        end
    end

    // Architectural values, kept across a flush
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                arch_val[r] <= '0;
            end
        end else begin
            for (int c = 0; c < PIPE_WIDTH; c++) begin
                if (commit_ports[c].we && commit_ports[c].has_rd && commit_ports[c].rd != '0) begin
                    arch_val[commit_ports[c].rd] <= commit_ports[c].data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rob_tag_alloc.sv
//--------------------------------------------------------------------------
// ROB tag allocator
// Circular head/tail pointers, all-or-nothing grants, frees on commit
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rob_tag_alloc (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            flush,
    input  logic [uarch_pkg::PIPE_WIDTH-1:0] rob_alloc_req,
    output logic [uarch_pkg::PIPE_WIDTH-1:0] rob_alloc_gnt,
    output uarch_pkg::tag_group_t            rob_alloc_tags,
    input  uarch_pkg::commit_group_t         commit_ports
);
    import uarch_pkg::*;

    // Extra MSB on each pointer tells full from empty
    typedef logic [TAG_WIDTH:0] rob_ptr_t;

    rob_ptr_t head;
    rob_ptr_t tail;
    rob_ptr_t occupancy;
    rob_ptr_t free_cnt;
    rob_ptr_t req_cnt;
    rob_ptr_t gnt_cnt;
    rob_ptr_t commit_cnt;

    assign occupancy = tail - head;
    assign free_cnt  = rob_ptr_t'(ROB_DEPTH) - occupancy;

    always_comb begin
        req_cnt    = '0;
        gnt_cnt    = '0;
        commit_cnt = '0;
        for (int i = 0; i < PIPE_WIDTH; i++) begin
            req_cnt    = req_cnt + rob_ptr_t'(rob_alloc_req[i]);
            gnt_cnt    = gnt_cnt + rob_ptr_t'(rob_alloc_gnt[i]);
            commit_cnt = commit_cnt + rob_ptr_t'(commit_ports[i].we);
        end
    end

    // Grant everything or nothing
    assign rob_alloc_gnt = (req_cnt <= free_cnt) ? rob_alloc_req : '0;

    // Requesting slots take consecutive tags, a lone slot 1 gets the tail
    assign rob_alloc_tags[0] = tail[TAG_WIDTH-1:0];
    assign rob_alloc_tags[1] = rob_alloc_req[0] ? rob_tag_t'(tail[TAG_WIDTH-1:0] + 1'b1)
                                                : tail[TAG_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
            tail <= '0;
        end else begin
            head <= head + commit_cnt;
            tail <= tail + gnt_cnt;
        end
    end

endmodule

`default_nettype wire

// File: rename.sv
//--------------------------------------------------------------------------
// Two-wide rename stage
// Source lookup, intra-group forwarding, commit bypass, compaction,
// output register and dispatch credit counter
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rename #(
    parameter int DISPATCH_CREDITS = 4
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           flush,
    output logic                                           rename_rdy,
    input  uarch_pkg::decoded_group_t                      decoded_insts,
    output logic [uarch_pkg::PIPE_WIDTH-1:0]               rob_alloc_req,
    input  logic [uarch_pkg::PIPE_WIDTH-1:0]               rob_alloc_gnt,
    input  uarch_pkg::tag_group_t                          rob_alloc_tags,
    output isa_pkg::arch_reg_t [uarch_pkg::PIPE_WIDTH-1:0] rs1,
    output isa_pkg::arch_reg_t [uarch_pkg::PIPE_WIDTH-1:0] rs2,
    input  uarch_pkg::source_t [uarch_pkg::PIPE_WIDTH-1:0] rs1_read,
    input  uarch_pkg::source_t [uarch_pkg::PIPE_WIDTH-1:0] rs2_read,
    output uarch_pkg::rat_write_group_t                    rat_writes,
    input  uarch_pkg::commit_group_t                       commit_ports,
    output uarch_pkg::renamed_group_t                      renamed_insts,
    input  logic                                           credit_return
);
    import isa_pkg::*;
    import uarch_pkg::*;

    localparam int CNT_W = $clog2(DISPATCH_CREDITS + 1);
    typedef logic [CNT_W-1:0] credit_cnt_t;

    credit_cnt_t    credit_cnt;
    logic           can_send;
    logic           group_taken;
    renamed_group_t renamed_tmp;
    renamed_group_t renamed_next;
    renamed_group_t renamed_q;

    //--------------------------------------------------------------------------
    // Helpers
    //--------------------------------------------------------------------------
    // Producer retiring this cycle: take its value instead of the tag
    function automatic source_t commit_bypass(input source_t src, input commit_group_t cp);
        source_t res;
        res = src;
        for (int c = 0; c < PIPE_WIDTH; c++) begin
            if (src.is_renamed && cp[c].we && cp[c].tag == src.tag) begin
                res.is_renamed = 1'b0;
                res.tag        = '0;
                res.data       = cp[c].data;
            end
        end
        return res;
    endfunction

    function automatic renamed_inst_t bypass_inst(input renamed_inst_t inst,
                                                  input commit_group_t cp);
        renamed_inst_t res;
        res       = inst;
        res.src_a = commit_bypass(inst.src_a, cp);
        res.src_b = commit_bypass(inst.src_b, cp);
        return res;
    endfunction

    function automatic renamed_inst_t build_inst(input decoded_inst_t d, input source_t a,
                                                 input source_t b, input rob_tag_t tag,
                                                 input logic gnt);
        renamed_inst_t r;
        r.valid    = d.valid && gnt;
        r.pc       = d.pc;
        r.opcode   = d.opcode;
        r.rd       = d.rd;
        r.has_rd   = d.has_rd;
        r.dest_tag = tag;
        r.src_a    = a;
        // Immediate operand is always ready
        if (d.use_imm) begin
            r.src_b = '{is_renamed: 1'b0, tag: '0, data: d.imm};
        end else begin
            r.src_b = b;
        end
        return r;
    endfunction

    //--------------------------------------------------------------------------
    // Handshakes
    //--------------------------------------------------------------------------
    assign can_send = (credit_cnt != '0) && !flush;

    always_comb begin
        for (int i = 0; i < PIPE_WIDTH; i++) begin
            rob_alloc_req[i] = decoded_insts[i].valid && can_send;
            rs1[i]           = decoded_insts[i].rs1;
            rs2[i]           = decoded_insts[i].rs2;
            // x0 filtering happens in the status file
            rat_writes[i].we   = decoded_insts[i].valid && rob_alloc_gnt[i] &&
                                 decoded_insts[i].has_rd;
            rat_writes[i].addr = decoded_insts[i].rd;
            rat_writes[i].tag  = rob_alloc_tags[i];
        end
    end

    // Grant is all or nothing, so equality means the whole group fits
    assign rename_rdy  = can_send && (rob_alloc_gnt == rob_alloc_req);
    assign group_taken = rename_rdy && (decoded_insts[0].valid || decoded_insts[1].valid);

    //--------------------------------------------------------------------------
    // Rename datapath
    //--------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < PIPE_WIDTH; i++) begin
            renamed_tmp[i] = build_inst(decoded_insts[i], rs1_read[i], rs2_read[i],
                                        rob_alloc_tags[i], rob_alloc_gnt[i]);
        end

        // Slot 1 depends on slot 0's result
        if (rat_writes[0].we && rat_writes[0].addr != '0) begin
            if (decoded_insts[1].rs1 == rat_writes[0].addr) begin
                renamed_tmp[1].src_a = '{is_renamed: 1'b1, tag: rob_alloc_tags[0], data: '0};
            end
            if (!decoded_insts[1].use_imm && decoded_insts[1].rs2 == rat_writes[0].addr) begin
                renamed_tmp[1].src_b = '{is_renamed: 1'b1, tag: rob_alloc_tags[0], data: '0};
            end
        end

        for (int i = 0; i < PIPE_WIDTH; i++) begin
            renamed_tmp[i] = bypass_inst(renamed_tmp[i], commit_ports);
        end

        // Lone slot 1 moves down
        if (!renamed_tmp[0].valid && renamed_tmp[1].valid) begin
            renamed_next[0] = renamed_tmp[1];
            renamed_next[1] = '0;
        end else begin
            renamed_next = renamed_tmp;
        end
    end

    // Output lives for one cycle, valids are zero when nothing was taken
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            renamed_q <= '0;
        end else begin
            renamed_q <= renamed_next;
        end
    end

    // Commits during the output cycle
    always_comb begin
        for (int i = 0; i < PIPE_WIDTH; i++) begin
            renamed_insts[i] = bypass_inst(renamed_q[i], commit_ports);
        end
    end

    //--------------------------------------------------------------------------
    // Dispatch credits
    //--------------------------------------------------------------------------
    // One credit per group, charged at acceptance
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            credit_cnt <= credit_cnt_t'(DISPATCH_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - credit_cnt_t'(group_taken) + credit_cnt_t'(credit_return);
        end
    end

endmodule

`default_nettype wire

// File: rename_top.sv
//--------------------------------------------------------------------------
// Rename top level
// Renamer with its register status file and ROB tag allocator
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rename_top #(
    parameter int DISPATCH_CREDITS = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  uarch_pkg::decoded_group_t decoded_insts,
    output logic                      rename_rdy,
    input  uarch_pkg::commit_group_t  commit_ports,
    output uarch_pkg::renamed_group_t renamed_insts,
    input  logic                      credit_return
);
    import isa_pkg::*;
    import uarch_pkg::*;

    // Allocator handshake
    logic [PIPE_WIDTH-1:0] rob_alloc_req;
    logic [PIPE_WIDTH-1:0] rob_alloc_gnt;
    tag_group_t            rob_alloc_tags;

    // Status file ports
    arch_reg_t [PIPE_WIDTH-1:0] rs1;
    arch_reg_t [PIPE_WIDTH-1:0] rs2;
    source_t   [PIPE_WIDTH-1:0] rs1_read;
    source_t   [PIPE_WIDTH-1:0] rs2_read;
    rat_write_group_t           rat_writes;

    rename #(
        .DISPATCH_CREDITS(DISPATCH_CREDITS)
    ) rename0 (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .rename_rdy(rename_rdy),
        .decoded_insts(decoded_insts),
        .rob_alloc_req(rob_alloc_req),
        .rob_alloc_gnt(rob_alloc_gnt),
        .rob_alloc_tags(rob_alloc_tags),
        .rs1(rs1),
        .rs2(rs2),
        .rs1_read(rs1_read),
        .rs2_read(rs2_read),
        .rat_writes(rat_writes),
        .commit_ports(commit_ports),
        .renamed_insts(renamed_insts),
        .credit_return(credit_return)
    );

    reg_status_file rsf0 (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .rs1(rs1),
        .rs2(rs2),
        .rs1_read(rs1_read),
        .rs2_read(rs2_read),
        .rat_writes(rat_writes),
        .commit_ports(commit_ports)
    );

    rob_tag_alloc alloc0 (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .rob_alloc_req(rob_alloc_req),
        .rob_alloc_gnt(rob_alloc_gnt),
        .rob_alloc_tags(rob_alloc_tags),
        .commit_ports(commit_ports)
    );

endmodule

`default_nettype wire

// File: rename_asserts.sv
//--------------------------------------------------------------------------
// Concurrent assertions for the rename stage, bound to rename
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rename_asserts #(
    parameter int DISPATCH_CREDITS = 4
) (
    input logic                                    clk,
    input logic                                    rst,
    input uarch_pkg::renamed_group_t               renamed_insts,
    input logic [$clog2(DISPATCH_CREDITS + 1)-1:0] credit_cnt
);

    // Failures seen so far, read by the testbench
    int unsigned assert_fails = 0;

    // Compaction fills slot 0 first
    slot_order: assert property (@(posedge clk) disable iff (rst)
        renamed_insts[1].valid |-> renamed_insts[0].valid)
        else begin
            $error("slot 1 valid while slot 0 is empty");
            assert_fails++;
        end

    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= DISPATCH_CREDITS)
        else begin
            $error("credit count above its maximum");
            assert_fails++;
        end

    // A group on the output was accepted while a credit was held
    credit_held: assert property (@(posedge clk) disable iff (rst)
        renamed_insts[0].valid |-> $past(credit_cnt) != '0)
        else begin
            $error("group sent without a credit");
            assert_fails++;
        end

    out_after_reset: assert property (@(posedge clk)
        $past(rst) |-> !renamed_insts[0].valid && !renamed_insts[1].valid)
        else begin
            $error("renamed output valid after reset");
            assert_fails++;
        end

endmodule

bind rename rename_asserts #(
    .DISPATCH_CREDITS(DISPATCH_CREDITS)
) asserts0 (
    .clk(clk),
    .rst(rst),
    .renamed_insts(renamed_insts),
    .credit_cnt(credit_cnt)
);

`default_nettype wire

// File: tb_rename.sv
//--------------------------------------------------------------------------
// Random testbench for the rename stage
// Reference model of the rename map, outstanding ROB tags and credits,
// retire side of the ROB and the dispatch credit return
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_rename;
    import isa_pkg::*;
    import uarch_pkg::*;

    localparam int CREDITS        = 4;
    localparam int NUM_GROUPS     = 300;
    localparam int TIMEOUT_CYCLES = 20 * NUM_GROUPS;

    logic           clk;
    logic           rst;
    logic           flush;
    decoded_group_t decoded_insts;
    logic           rename_rdy;
    commit_group_t  commit_ports;
    renamed_group_t renamed_insts;
    logic           credit_return;

    // Reference model state
    logic           ref_map_v [ARCH_REGS];
    rob_tag_t       ref_map_t [ARCH_REGS];
    xlen_t          ref_arch  [ARCH_REGS];
    commit_port_t   rob_q[$];
    rob_tag_t       next_tag;
    int             credits;
    int             credits_owed;
    renamed_group_t exp_out;

    int             n_commit;
    bit             grp_pending;
    int             accepted;
    int             cycles;
    int unsigned    seed_init;

    rename_top #(
        .DISPATCH_CREDITS(CREDITS)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .decoded_insts(decoded_insts),
        .rename_rdy(rename_rdy),
        .commit_ports(commit_ports),
        .renamed_insts(renamed_insts),
        .credit_return(credit_return)
    );

    always #20 clk = ~clk;

    //--------------------------------------------------------------------------
    // Error handling
    //--------------------------------------------------------------------------
    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic expect_eq(input logic [63:0] got, input logic [63:0] exp,
                             input string name);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic bit assertions_failed();
        return dut0.rename0.asserts0.assert_fails != 0;
    endfunction

    // Cycle limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: not all groups were renamed within %0d cycles",
                     TIMEOUT_CYCLES);
            abort_run();
        end
    end

    //--------------------------------------------------------------------------
    // Model lookups
    //--------------------------------------------------------------------------
    function automatic source_t lookup_src(input arch_reg_t r);
        if (r == '0) begin
            return '0;
        end
        if (ref_map_v[r]) begin
            return '{is_renamed: 1'b1, tag: ref_map_t[r], data: '0};
        end
        return '{is_renamed: 1'b0, tag: '0, data: ref_arch[r]};
    endfunction

    // Producer retiring in this cycle delivers its value
    function automatic source_t apply_commits(input source_t s, input commit_group_t cp);
        source_t r;
        r = s;
        for (int c = 0; c < PIPE_WIDTH; c++) begin
            if (s.is_renamed && cp[c].we && cp[c].tag == s.tag) begin
                r = '{is_renamed: 1'b0, tag: '0, data: cp[c].data};
            end
        end
        return r;
    endfunction

    // Expected output group for a decode group accepted this cycle
    function automatic renamed_group_t predict_group(input decoded_group_t d,
                                                     input commit_group_t cp);
        renamed_group_t g;
        rob_tag_t       t;
        int             n;
        g = '0;
        t = next_tag;
        n = 0;
        for (int i = 0; i < PIPE_WIDTH; i++) begin
            if (d[i].valid) begin
                g[n].valid    = 1'b1;
                g[n].pc       = d[i].pc;
                g[n].opcode   = d[i].opcode;
                g[n].rd       = d[i].rd;
                g[n].has_rd   = d[i].has_rd;
                g[n].dest_tag = t;
                g[n].src_a    = lookup_src(d[i].rs1);
                if (d[i].use_imm) begin
                    g[n].src_b = '{is_renamed: 1'b0, tag: '0, data: d[i].imm};
                end else begin
                    g[n].src_b = lookup_src(d[i].rs2);
                end
                // Older slot's new mapping beats the table
                if (i == 1 && d[0].valid && d[0].has_rd && d[0].rd != '0) begin
                    if (d[1].rs1 == d[0].rd) begin
                        g[n].src_a = '{is_renamed: 1'b1, tag: g[0].dest_tag, data: '0};
                    end
                    if (!d[1].use_imm && d[1].rs2 == d[0].rd) begin
                        g[n].src_b = '{is_renamed: 1'b1, tag: g[0].dest_tag, data: '0};
                    end
                end
                g[n].src_a = apply_commits(g[n].src_a, cp);
                g[n].src_b = apply_commits(g[n].src_b, cp);
                t = t + 1'b1;
                n++;
            end
        end
        return g;
    endfunction

    //--------------------------------------------------------------------------
    // Stimulus
    //--------------------------------------------------------------------------
    // Small register range so dependences are frequent
    function automatic decoded_group_t random_group();
        decoded_group_t d;
        int             pattern;
        pattern = 1 + ($urandom % 3);
        for (int i = 0; i < PIPE_WIDTH; i++) begin
            d[i].valid   = pattern[i];
            d[i].pc      = $urandom;
            d[i].opcode  = opcode_t'($urandom);
            d[i].rd      = arch_reg_t'($urandom % 8);
            d[i].has_rd  = ($urandom % 5) != 0;
            d[i].rs1     = arch_reg_t'($urandom % 8);
            d[i].rs2     = arch_reg_t'($urandom % 8);
            d[i].use_imm = ($urandom % 4) == 0;
            d[i].imm     = $urandom;
        end
        return d;
    endfunction

    task automatic drive_inputs();
        flush         = ($urandom % 64) == 0;
        commit_ports  = '0;
        credit_return = 1'b0;
        n_commit      = 0;
        if (!flush) begin
            // Oldest outstanding tags retire, slot 0 first
            // Sparse retirement lets the ROB fill up
            if (($urandom % 5) == 0) begin
                n_commit = 1 + ($urandom % 2);
            end
            if (n_commit > rob_q.size()) begin
                n_commit = rob_q.size();
            end
            for (int c = 0; c < n_commit; c++) begin
                commit_ports[c]      = rob_q[c];
                commit_ports[c].data = $urandom;
            end
            if (credits_owed > 0 && ($urandom % 2) == 1) begin
                credit_return = 1'b1;
            end
        end
        // Decode holds a group until it is taken
        if (!grp_pending) begin
            decoded_insts = '0;
            if (accepted < NUM_GROUPS && ($urandom % 4) != 0) begin
                decoded_insts = random_group();
                grp_pending   = 1'b1;
            end
        end
    endtask

    //--------------------------------------------------------------------------
    // Checks and model update for one cycle
    //--------------------------------------------------------------------------
    task automatic check_and_advance();
        renamed_group_t got;
        renamed_group_t exp;
        renamed_group_t nxt;
        commit_port_t   cp;
        bit             exp_rdy;
        bit             taken;
        int             nreq;
        string          slot;

        if (assertions_failed()) begin
            $display("An assertion on the rename stage failed at %0d ns", $time);
            abort_run();
        end

        // Output of the previous acceptance
        got = renamed_insts;
        for (int i = 0; i < PIPE_WIDTH; i++) begin
            exp[i]       = exp_out[i];
            exp[i].src_a = apply_commits(exp_out[i].src_a, commit_ports);
            exp[i].src_b = apply_commits(exp_out[i].src_b, commit_ports);
            slot         = $sformatf("renamed_insts[%0d]", i);
            expect_eq(got[i].valid, exp[i].valid, {slot, ".valid"});
            if (exp[i].valid) begin
                expect_eq(got[i].dest_tag, exp[i].dest_tag, {slot, ".dest_tag"});
                expect_eq(got[i].pc, exp[i].pc, {slot, ".pc"});
                expect_eq(got[i].opcode, exp[i].opcode, {slot, ".opcode"});
                expect_eq(got[i].rd, exp[i].rd, {slot, ".rd"});
                expect_eq(got[i].has_rd, exp[i].has_rd, {slot, ".has_rd"});
                expect_eq(got[i].src_a, exp[i].src_a, {slot, ".src_a"});
                expect_eq(got[i].src_b, exp[i].src_b, {slot, ".src_b"});
            end
        end
        if (got[0].valid || got[1].valid) begin
            credits_owed++;
        end

        // Back-pressure from credits or a full ROB
        nreq    = int'(decoded_insts[0].valid) + int'(decoded_insts[1].valid);
        exp_rdy = !flush && credits > 0 && (rob_q.size() + nreq <= ROB_DEPTH);
        expect_eq(rename_rdy, exp_rdy, "rename_rdy");
        taken = exp_rdy && nreq > 0;
        nxt   = '0;
        if (taken) begin
            nxt = predict_group(decoded_insts, commit_ports);
        end

        // Clock edge: commits first, then new mappings
        for (int c = 0; c < n_commit; c++) begin
            cp = rob_q.pop_front();
            cp.data = commit_ports[c].data;
            if (cp.has_rd && cp.rd != '0) begin
                ref_arch[cp.rd] = cp.data;
            end
            if (cp.has_rd && ref_map_v[cp.rd] && ref_map_t[cp.rd] == cp.tag) begin
                ref_map_v[cp.rd] = 1'b0;
            end
        end

        if (flush) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                ref_map_v[r] = 1'b0;
            end
            rob_q.delete();
            next_tag     = '0;
            credits      = CREDITS;
            credits_owed = 0;
            exp_out      = '0;
        end else begin
            credits      = credits - int'(taken) + int'(credit_return);
            credits_owed = credits_owed - int'(credit_return);
            for (int i = 0; i < PIPE_WIDTH; i++) begin
                if (nxt[i].valid) begin
                    rob_q.push_back('{we: 1'b1, tag: nxt[i].dest_tag, rd: nxt[i].rd,
                                      has_rd: nxt[i].has_rd, data: '0});
                    // Slot 1 comes last and wins on equal rd
                    if (nxt[i].has_rd && nxt[i].rd != '0) begin
                        ref_map_v[nxt[i].rd] = 1'b1;
                        ref_map_t[nxt[i].rd] = nxt[i].dest_tag;
                    end
                    next_tag = next_tag + 1'b1;
                end
            end
            exp_out = nxt;
            if (taken) begin
                accepted++;
                grp_pending = 1'b0;
            end
        end
    endtask

    //--------------------------------------------------------------------------
    // Main sequence
    //--------------------------------------------------------------------------
    initial begin
        seed_init     = $urandom(32'h35f8_4c4d);
        clk           = 1'b0;
        rst           = 1'b1;
        flush         = 1'b0;
        decoded_insts = '0;
        commit_ports  = '0;
        credit_return = 1'b0;
        for (int r = 0; r < ARCH_REGS; r++) begin
            ref_map_v[r] = 1'b0;
            ref_map_t[r] = '0;
            ref_arch[r]  = '0;
        end
        next_tag     = '0;
        credits      = CREDITS;
        credits_owed = 0;
        exp_out      = '0;
        grp_pending  = 1'b0;
        accepted     = 0;
        cycles       = 0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Every accepted group is compared in its output cycle
        while (accepted < NUM_GROUPS || exp_out[0].valid) begin
            drive_inputs();
            #5;
            check_and_advance();
            @(negedge clk);
        end

        // Assertions sampled at the last clock edge
        if (assertions_failed()) begin
            $display("An assertion on the rename stage failed at %0d ns", $time);
            abort_run();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
isa_pkg.sv
uarch_pkg.sv
reg_status_file.sv
rob_tag_alloc.sv
rename.sv
rename_top.sv
rename_asserts.sv
tb_rename.sv
